/* Bender.yml */
package:
  name: memaccess

sources:
  - include_dirs:
      - .
    files:
      - memPkg.sv
      - accessIf.sv
      - ramBusIf.sv
      - memArbiter.sv
      - byteSequencer.sv
      - byteRam.sv
      - memTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbMemTop.sv

/* accessIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface accessIf import memPkg::*; ();

    // request side, driven by the arbiter
    logic start;
    logic write;
    addrT addr;
    lenT  len;
    wordT wdata;

    // completion side, driven by the sequencer
    logic busy;
    logic done;
    wordT rdata;

    modport arb (
        output start, write, addr, len, wdata,
        input  busy, done, rdata
    );

    modport seq (
        input  start, write, addr, len, wdata,
        output busy, done, rdata
    );

endinterface

`default_nettype wire

/* byteRam.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module byteRam import memPkg::*; #(
    parameter int depth = `MEM_DEPTH
) (
    input  logic clk,
    ramBusIf.ram bus
);

    localparam int idxWidth = $clog2(depth);

    byteT mem [depth];

    logic [idxWidth-1:0] idx;

    // upper address bits wrap when the RAM is smaller than the address space
    assign idx = bus.addr[idxWidth-1:0];

    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[idx] <= bus.wdata;
        end
        // read returns the old byte on a write to the same address
        bus.rdata <= mem[idx];
    end

endmodule

`default_nettype wire

/* byteSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module byteSequencer import memPkg::*; (
    input  logic clk,
    input  logic rstN,
    accessIf.seq acc,
    ramBusIf.ctrl ram
);

    seqStateT   state;
    logic [2:0] stage;

    logic writeReg;
    addrT baseAddr;
    lenT  lenReg;
    wordT wdataReg;
    wordT word;

    logic       busy;
    logic       lastStep;
    logic       collect;
    logic [1:0] byteIdx;

    assign busy = (state == seqBusy);

    // stages 0..len drive the RAM, len+1 catches the last byte, len+2 is done
    assign lastStep = (stage == {1'b0, lenReg} + 3'd2);
    assign collect  = busy && !writeReg && (stage != 3'd0)
                      && (stage <= {1'b0, lenReg} + 3'd1);
    assign byteIdx  = stage[1:0] - 2'd1;

    assign ram.addr  = baseAddr + addrT'(stage);
    assign ram.wdata = wdataReg[8*stage[1:0] +: 8];
    assign ram.we    = busy && writeReg && (stage <= {1'b0, lenReg});

    assign acc.busy  = busy;
    assign acc.done  = busy && lastStep;
    assign acc.rdata = word;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= seqIdle;
            stage <= 3'd0;
        end else if (acc.start) begin
            state <= seqBusy;
            stage <= 3'd0;
        end else if (busy) begin
            if (lastStep) begin
                state <= seqIdle;
                stage <= 3'd0;
            end else begin
                stage <= stage + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc.start) begin
            writeReg <= acc.write;
            baseAddr <= acc.addr;
            lenReg   <= acc.len;
            wdataReg <= acc.wdata;
            // bytes above len stay zero, stores return zero
            word     <= '0;
        end else if (collect) begin
            word[8*byteIdx +: 8] <= ram.rdata;
        end
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
memPkg.sv
accessIf.sv
ramBusIf.sv
memArbiter.sv
byteSequencer.sv
byteRam.sv
memTop.sv
tbMemTop.sv

/* memArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memArbiter import memPkg::*; (
    input  logic clk,
    input  logic rstN,

    // instruction fetch port
    input  logic instEn,
    input  addrT instAddr,
    output logic instFree,
    output logic instOutEn,
    output wordT inst,

    // load/store port
    input  logic lsEn,
    input  logic lsWrite,
    input  addrT lsAddr,
    input  lenT  lsLen,
    input  wordT lsWdata,
    output logic lsFree,
    output logic lsOutEn,
    output wordT lsRdata,

    accessIf.arb acc
);

    logic instValid;
    addrT instSlotAddr;

    logic lsValid;
    logic lsSlotWrite;
    addrT lsSlotAddr;
    lenT  lsSlotLen;
    wordT lsSlotWdata;

    portT owner;
    logic seqReady;

    // the sequencer can take a new access while idle or in its done cycle
    assign seqReady = !acc.busy || acc.done;

    // load/store slot has priority over the fetch slot
    assign acc.start = seqReady && (lsValid || instValid);
    assign acc.write = lsValid && lsSlotWrite;
    assign acc.addr  = lsValid ? lsSlotAddr : instSlotAddr;
    assign acc.len   = lsValid ? lsSlotLen : lenT'(3);
    assign acc.wdata = lsSlotWdata;

    assign instFree = !instValid;
    assign lsFree   = !lsValid;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            instValid <= 1'b0;
            lsValid   <= 1'b0;
            owner     <= portInst;
            instOutEn <= 1'b0;
            lsOutEn   <= 1'b0;
        end else begin
            if (instEn && !instValid) begin
                instValid <= 1'b1;
            end else if (acc.start && !lsValid) begin
                instValid <= 1'b0;
            end

            if (lsEn && !lsValid) begin
                lsValid <= 1'b1;
            end else if (acc.start && lsValid) begin
                lsValid <= 1'b0;
            end

            if (acc.start) begin
                owner <= lsValid ? portLs : portInst;
            end

            // owner still names the finishing access here
            instOutEn <= acc.done && (owner == portInst);
            lsOutEn   <= acc.done && (owner == portLs);
        end
    end

    always_ff @(posedge clk) begin
        if (instEn && !instValid) begin
            instSlotAddr <= instAddr;
        end

        if (lsEn && !lsValid) begin
            lsSlotWrite <= lsWrite;
            lsSlotAddr  <= lsAddr;
            lsSlotLen   <= lsLen;
            lsSlotWdata <= lsWdata;
        end

        // the other port keeps its last result
        if (acc.done) begin
            if (owner == portLs) begin
                lsRdata <= acc.rdata;
            end else begin
                inst <= acc.rdata;
            end
        end
    end

endmodule

`default_nettype wire

/* memPkg.sv */
`default_nettype none

`include "mem_settings.svh"

package memPkg;

    // byte address into the shared RAM
    typedef logic [`MEM_ADDR_WIDTH-1:0] addrT;

    // instruction or data word
    typedef logic [`MEM_WORD_WIDTH-1:0] wordT;

    // one RAM byte
    typedef logic [7:0] byteT;

    // number of bytes minus one, only 0, 1 and 3 are used
    typedef logic [1:0] lenT;

    // owner of the access in flight
    typedef enum logic {
        portInst,
        portLs
    } portT;

    typedef enum logic {
        seqIdle,
        seqBusy
    } seqStateT;

endpackage

`default_nettype wire

/* memStimulus.txt */
# op: 0 fetch, 1 load, 2 store, 3 fetch and load in the same cycle (both expect the word)
# columns in hex: op addr len wdata expected, a store expects zero on lsRdata
2 00100 3 deadbeef 00000000
1 00100 3 00000000 deadbeef
0 00100 3 00000000 deadbeef
2 00101 0 0000005a 00000000
1 00100 3 00000000 dead5aef
2 00102 1 00001234 00000000
1 00100 3 00000000 12345aef
1 00103 0 00000000 00000012
1 00100 0 00000000 000000ef
1 00100 1 00000000 00005aef
1 00102 1 00000000 00001234
2 00200 3 0badf00d 00000000
3 00200 3 00000000 0badf00d
2 1fffc 3 a5c3e187 00000000
1 1fffe 1 00000000 0000a5c3
1 1ffff 0 00000000 000000a5
3 1fffc 3 00000000 a5c3e187
0 00200 3 00000000 0badf00d

/* memTop.sv */
`timescale 1ns/1ps
`default_nettype none

module memTop import memPkg::*; (
    input  logic clk,
    input  logic rstN,

    input  logic instEn,
    input  addrT instAddr,
    output logic instFree,
    output logic instOutEn,
    output wordT inst,

    input  logic lsEn,
    input  logic lsWrite,
    input  addrT lsAddr,
    input  lenT  lsLen,
    input  wordT lsWdata,
    output logic lsFree,
    output logic lsOutEn,
    output wordT lsRdata
);

    accessIf accBus ();
    ramBusIf ramBus ();

    memArbiter arb0 (
        .clk       (clk),
        .rstN      (rstN),
        .instEn    (instEn),
        .instAddr  (instAddr),
        .instFree  (instFree),
        .instOutEn (instOutEn),
        .inst      (inst),
        .lsEn      (lsEn),
        .lsWrite   (lsWrite),
        .lsAddr    (lsAddr),
        .lsLen     (lsLen),
        .lsWdata   (lsWdata),
        .lsFree    (lsFree),
        .lsOutEn   (lsOutEn),
        .lsRdata   (lsRdata),
        .acc       (accBus.arb)
    );

    byteSequencer seq0 (
        .clk  (clk),
        .rstN (rstN),
        .acc  (accBus.seq),
        .ram  (ramBus.ctrl)
    );

    byteRam ram0 (
        .clk (clk),
        .bus (ramBus.ram)
    );

endmodule

`default_nettype wire

/* mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// byte address width, covers the whole RAM
`define MEM_ADDR_WIDTH 17

// number of bytes in the shared RAM
`define MEM_DEPTH 131072

// width of an instruction or data word
`define MEM_WORD_WIDTH 32

`endif

/* ramBusIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface ramBusIf import memPkg::*; ();

    logic we;
    addrT addr;
    byteT wdata;
    // one cycle behind addr
    byteT rdata;

    modport ctrl (
        output we, addr, wdata,
        input  rdata
    );

    modport ram (
        input  we, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

/* tbMemTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module tbMemTop import memPkg::*; ();

    logic clk;
    logic rstN;
    logic instEn;
    logic instFree;
    logic instOutEn;
    logic lsEn;
    logic lsWrite;
    logic lsFree;
    logic lsOutEn;
    addrT instAddr;
    addrT lsAddr;
    lenT  lsLen;
    wordT inst;
    wordT lsWdata;
    wordT lsRdata;

    byteT refMem [`MEM_DEPTH];
    wordT expInst[$];
    wordT expLs[$];
    portT doneLog[$];
    logic [31:0] rngState;

    memTop dut0 (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // len+1 little-endian bytes from addr with the upper bytes zero
    function automatic wordT readModel(input addrT addr, input lenT len);
        wordT w;
        w = '0;
        for (int i = 0; i <= int'(len); i++) begin
            w[8*i +: 8] = refMem[addr + addrT'(i)];
        end
        return w;
    endfunction

    function automatic void writeModel(input addrT addr, input lenT len, input wordT data);
        for (int i = 0; i <= int'(len); i++) begin
            refMem[addr + addrT'(i)] = data[8*i +: 8];
        end
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(input wordT actual, input wordT expected, input string what);
        if (actual !== expected) begin
            failRun($sformatf("mismatch at %0t: %s is %h, expected %h",
                              $time, what, actual, expected));
        end
    endtask

    task automatic checkFlag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            failRun($sformatf("mismatch at %0t: %s is %b, expected %b",
                              $time, what, actual, expected));
        end
    endtask

    // results are sampled on the falling edge while the outputs are stable
    always @(negedge clk) begin
        if (rstN === 1'b1 && instOutEn === 1'b1) begin
            if (expInst.size() == 0) begin
                failRun("instOutEn pulsed with no fetch outstanding");
            end else begin
                checkWord(inst, expInst.pop_front(), "fetch result");
                doneLog.push_back(portInst);
            end
        end
        if (rstN === 1'b1 && lsOutEn === 1'b1) begin
            if (expLs.size() == 0) begin
                failRun("lsOutEn pulsed with no load or store outstanding");
            end else begin
                checkWord(lsRdata, expLs.pop_front(), "load/store result");
                doneLog.push_back(portLs);
            end
        end
    end

    // waits for the needed Free outputs and then holds En for one cycle
    task automatic sendRequests(input logic doInst, input addrT fetchAddr, input wordT instExp,
                                input logic doLs, input logic write, input addrT addr,
                                input lenT len, input wordT wdata, input wordT lsExp);
        int cycles;
        cycles = 0;
        while ((doInst && !instFree) || (doLs && !lsFree)) begin
            @(negedge clk);
            cycles++;
            if (cycles > 200) begin
                failRun(doLs && !lsFree ? "lsFree never went high" : "instFree never went high");
            end
        end
        instEn   = doInst;
        instAddr = fetchAddr;
        lsEn     = doLs;
        lsWrite  = write;
        lsAddr   = addr;
        lsLen    = len;
        lsWdata  = wdata;
        if (doInst) begin
            expInst.push_back(instExp);
        end
        if (doLs) begin
            expLs.push_back(lsExp);
            if (write) begin
                writeModel(addr, len, wdata);
            end
        end
        @(negedge clk);
        instEn = 1'b0;
        lsEn   = 1'b0;
    endtask

    task automatic drainResults();
        int cycles;
        cycles = 0;
        while (expInst.size() != 0 || expLs.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 200) begin
                failRun(expLs.size() != 0 ? "lsOutEn never pulsed" : "instOutEn never pulsed");
            end
        end
        @(negedge clk);
    endtask

    initial begin
        int fd;
        int fields;
        string line;
        logic [3:0] op;
        logic [31:0] r;
        logic doInst;
        logic doLs;
        addrT addr;
        addrT fetchAddr;
        lenT len;
        wordT wdata;
        wordT expected;
        clk = 1'b0;
        rstN = 1'b0;
        instEn = 1'b0;
        instAddr = '0;
        lsEn = 1'b0;
        lsWrite = 1'b0;
        lsAddr = '0;
        lsLen = '0;
        lsWdata = '0;
        rngState = 32'h1eda6be0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        checkFlag(instFree, 1'b1, "instFree after reset");
        checkFlag(lsFree, 1'b1, "lsFree after reset");
        checkFlag(instOutEn, 1'b0, "instOutEn after reset");
        checkFlag(lsOutEn, 1'b0, "lsOutEn after reset");

        fd = $fopen("memStimulus.txt", "r");
        if (fd == 0) begin
            failRun("could not open memStimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h", op, addr, len, wdata, expected);
            if (fields != 5) begin
                failRun("stimulus line has the wrong number of fields");
            end
            doneLog.delete();
            case (op)
                4'h0: sendRequests(1'b1, addr, expected, 1'b0, 1'b0, addr, len, wdata, '0);
                4'h1: sendRequests(1'b0, addr, '0, 1'b1, 1'b0, addr, len, wdata, expected);
                4'h2: sendRequests(1'b0, addr, '0, 1'b1, 1'b1, addr, len, wdata, expected);
                default: sendRequests(1'b1, addr, expected, 1'b1, 1'b0, addr, len, wdata,
                                      expected);
            endcase
            drainResults();
            if (op == 4'h3) begin
                checkFlag(doneLog[0] == portLs, 1'b1, "lsOutEn before instOutEn");
            end
        end
        $fclose(fd);

        // fill the data window at 0x8000 and the fetch window at 0x8040
        // later stores stay below the fetch window
        for (int i = 0; i < 32; i++) begin
            rngState = xorshift32(rngState);
            sendRequests(1'b0, '0, '0, 1'b1, 1'b1, 17'h08000 + addrT'(4 * i), 2'd3,
                         rngState, '0);
        end
        drainResults();

        for (int n = 0; n < 40; n++) begin
            rngState = xorshift32(rngState);
            r = rngState;
            len = (r[3:2] == 2'd0) ? 2'd0 : (r[3:2] == 2'd1) ? 2'd1 : 2'd3;
            addr = 17'h08000 + (addrT'(r[9:4]) & ~addrT'(len));
            fetchAddr = 17'h08040 + (addrT'(r[15:10]) & 17'h0003c);
            doInst = (r[17:16] != 2'd1);
            doLs = (r[17:16] != 2'd0);
            wdata = xorshift32(r);
            expected = r[18] ? '0 : readModel(addr, len);
            sendRequests(doInst, fetchAddr, readModel(fetchAddr, 2'd3), doLs, r[18], addr,
                         len, wdata, expected);
        end
        drainResults();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
